// ==== hw/lb_board_pkg.sv ====
// ------------------------------------------------
// Address map, identity words and reset defaults
// for the board local-bus slave. Imported by the
// RTL blocks and by the testbench.
// ------------------------------------------------
`default_nettype none

package lb_board_pkg;

	// bus widths
	localparam int LB_AW = 24;
	localparam int LB_DW = 32;

	// ------------------------------------------------
	// page map, upper address byte
	// ------------------------------------------------
	localparam logic [7:0] PAGE_STATUS = 8'h00;
	localparam logic [7:0] PAGE_CTRL = 8'h05;
	localparam logic [LB_DW-1:0] UNMAPPED_WORD = 32'hdeadbeef;

	// identity words, plain ASCII
	localparam logic [LB_DW-1:0] ID_WORD_0 = "Boar";
	localparam logic [LB_DW-1:0] ID_WORD_1 = "d sl";
	localparam logic [LB_DW-1:0] ID_WORD_2 = "ave ";
	localparam logic [LB_DW-1:0] ID_WORD_3 = "lb01";

	// status page offsets past the identity words
	localparam logic [3:0] ST_FAULT_CNT = 4'h4;
	localparam logic [3:0] ST_UPTIME = 4'h5;
	localparam logic [3:0] ST_MAC_STAT = 4'h6;
	localparam logic [3:0] ST_PWM_STAT = 4'h7;

	// ------------------------------------------------
	// control page, decoded on the low five bits
	// ------------------------------------------------
	localparam int MIRROR_AW = 5;
	localparam logic [MIRROR_AW-1:0] CR_LED_USER = 5'd1;
	localparam logic [MIRROR_AW-1:0] CR_LED1_DUTY = 5'd2;
	localparam logic [MIRROR_AW-1:0] CR_LED2_DUTY = 5'd3;
	localparam logic [MIRROR_AW-1:0] CR_MISC_CONFIG = 5'd8;

	// pwm counter width, also sets the uptime tick rate
	localparam int LED_CW = 10;

	localparam logic [7:0] MISC_CONFIG_DEFAULT = 8'h0a;

endpackage

`default_nettype wire

// ==== hw/lb_status_bank.sv ====
// ------------------------------------------------
// Read-only status words for page 0: identity,
// fault count, uptime, MAC status and LED levels.
// Loaded on the first cycle of a read.
// ------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module lb_status_bank
	import lb_board_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire rd_stb,
	input wire [3:0] addr_lo,
	input wire xdomain_fault,
	input wire tx_mac_done,
	input wire [1:0] rx_mac_buf_status,
	input wire led_tick,
	input wire led1,
	input wire led2,
	output logic [LB_DW-1:0] status_word
);

	logic [15:0] fault_cnt;
	logic [LB_DW-1:0] uptime;
	logic tx_mac_done_r;
	logic [1:0] rx_mac_buf_status_r;

	// ------------------------------------------------
	// counters
	// ------------------------------------------------
	// clock-domain faults come in bursts at power-up
	always_ff @(posedge clk) begin
		if (rst) begin
			fault_cnt <= '0;
		end else if (xdomain_fault) begin
			fault_cnt <= fault_cnt + 16'd1;
		end
	end

	// one tick per pwm period
	always_ff @(posedge clk) begin
		if (rst) begin
			uptime <= '0;
		end else if (led_tick) begin
			uptime <= uptime + 32'd1;
		end
	end

	// MAC flags arrive from another block, register once
	always_ff @(posedge clk) begin
		if (rst) begin
			tx_mac_done_r <= 1'b0;
			rx_mac_buf_status_r <= 2'b00;
		end else begin
			tx_mac_done_r <= tx_mac_done;
			rx_mac_buf_status_r <= rx_mac_buf_status;
		end
	end

	// ------------------------------------------------
	// first read cycle
	// ------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			status_word <= '0;
		end else if (rd_stb) begin
			case (addr_lo)
				4'h0: status_word <= ID_WORD_0;
				4'h1: status_word <= ID_WORD_1;
				4'h2: status_word <= ID_WORD_2;
				4'h3: status_word <= ID_WORD_3;
				ST_FAULT_CNT: status_word <= {16'd0, fault_cnt};
				ST_UPTIME: status_word <= uptime;
				ST_MAC_STAT: status_word <= {29'd0, rx_mac_buf_status_r, tx_mac_done_r};
				ST_PWM_STAT: status_word <= {30'd0, led2, led1};
				// offsets 8 to 15 are reserved
				default: status_word <= '0;
			endcase
		end
	end

	// count only steps by one, wrap included
	fault_cnt_steps: assert property (@(posedge clk) disable iff (rst)
		(!$past(rst) && (fault_cnt != $past(fault_cnt)))
		|-> (fault_cnt == $past(fault_cnt) + 16'd1));

endmodule

`default_nettype wire

// ==== hw/lb_control_regs.sv ====
// ------------------------------------------------
// Control page write decode. Holds the LED and
// configuration registers and flags every page
// write for the mirror RAM.
// ------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module lb_control_regs
	import lb_board_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire [LB_AW-1:0] addr,
	input wire [LB_DW-1:0] data_out,
	input wire wr_en,
	output logic mirror_we,
	output logic led_user_mode,
	output logic [7:0] led1_duty,
	output logic [7:0] led2_duty,
	output logic [3:0] cfg_config,
	output logic [3:0] ext_config
);

	logic ctrl_hit;
	logic [7:0] misc_config;

	// page match on the upper address byte
	assign ctrl_hit = wr_en && (addr[LB_AW-1 -: 8] == PAGE_CTRL);

	// every write to the page lands in the mirror,
	// mapped register or not
	assign mirror_we = ctrl_hit;

	// ------------------------------------------------
	// register file
	// ------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			led_user_mode <= 1'b0;
			led1_duty <= 8'd0;
			led2_duty <= 8'd0;
			misc_config <= MISC_CONFIG_DEFAULT;
		end else if (ctrl_hit) begin
			case (addr[MIRROR_AW-1:0])
				CR_LED_USER: led_user_mode <= data_out[0];
				CR_LED1_DUTY: led1_duty <= data_out[7:0];
				CR_LED2_DUTY: led2_duty <= data_out[7:0];
				CR_MISC_CONFIG: misc_config <= data_out[7:0];
				// other offsets only reach the mirror
				default: ;
			endcase
		end
	end

	// config byte split, board straps low and
	// expansion controls high
	assign cfg_config = misc_config[3:0];
	assign ext_config = misc_config[7:4];

endmodule

`default_nettype wire

// ==== hw/led_pwm.sv ====
// ------------------------------------------------
// Free-running PWM for the two board LEDs. The
// counter carry doubles as the uptime tick.
// ------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module led_pwm
	import lb_board_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire [7:0] led1_duty,
	input wire [7:0] led2_duty,
	output logic led1,
	output logic led2,
	output logic led_tick
);

	logic [LED_CW-1:0] led_cc;
	logic [7:0] duty1_q;
	logic [7:0] duty2_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			led_cc <= '0;
			led_tick <= 1'b0;
			duty1_q <= 8'd0;
			duty2_q <= 8'd0;
			led1 <= 1'b0;
			led2 <= 1'b0;
		end else begin
			{led_tick, led_cc} <= {1'b0, led_cc} + {{LED_CW{1'b0}}, 1'b1};
			// new duty only at a period boundary, so
			// each period is clean
			if (&led_cc) begin
				duty1_q <= led1_duty;
				duty2_q <= led2_duty;
			end
			// duty scaled by 4 over the 10-bit count
			led1 <= led_cc < {duty1_q, 2'b00};
			led2 <= led_cc < {duty2_q, 2'b00};
		end
	end

	// ------------------------------------------------
	// zero duty taken at a period boundary keeps the
	// LED dark once it reaches the comparator
	// ------------------------------------------------
	led1_dark: assert property (@(posedge clk) disable iff (rst)
		($past(&led_cc, 2) && ($past(led1_duty, 2) == 8'd0)) |-> !led1);
	led2_dark: assert property (@(posedge clk) disable iff (rst)
		($past(&led_cc, 2) && ($past(led2_duty, 2) == 8'd0)) |-> !led2);

endmodule

`default_nettype wire

// ==== hw/lb_mirror_ram.sv ====
// ------------------------------------------------
// Mirror of control page writes. Simple dual-port
// RAM with a registered read port.
// ------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module lb_mirror_ram
	import lb_board_pkg::*;
(
	input wire clk,
	input wire we,
	input wire [MIRROR_AW-1:0] wr_addr,
	input wire [LB_DW-1:0] wr_data,
	input wire rd_en,
	input wire [MIRROR_AW-1:0] rd_addr,
	output logic [LB_DW-1:0] rd_data
);

	logic [LB_DW-1:0] mem [2**MIRROR_AW];

	// write port
	always_ff @(posedge clk) begin
		if (we) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// read port, first cycle of the bus read
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

`default_nettype wire

// ==== hw/lb_board_slave.sv ====
// ------------------------------------------------
// Board local-bus slave, top level. Reads take two
// cycles: status or mirror word first, then the
// page select into data_in.
// ------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module lb_board_slave
	import lb_board_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire [LB_AW-1:0] addr,
	input wire control_strobe,
	input wire control_rd,
	input wire [LB_DW-1:0] data_out,
	input wire xdomain_fault,
	input wire tx_mac_done,
	input wire [1:0] rx_mac_buf_status,
	output logic [LB_DW-1:0] data_in,
	output logic led_user_mode,
	output logic led1,
	output logic led2,
	output logic [3:0] cfg_config,
	output logic [3:0] ext_config
);

	logic rd_stb;
	logic wr_en;
	logic rd_stb_r;
	logic [LB_AW-1:0] addr_r;
	logic [LB_DW-1:0] status_word;
	logic [LB_DW-1:0] mirror_word;
	logic mirror_we;
	logic led_tick;
	logic [7:0] led1_duty;
	logic [7:0] led2_duty;

	assign rd_stb = control_strobe & control_rd;
	assign wr_en = control_strobe & ~control_rd;

	// ------------------------------------------------
	// read pipeline
	// ------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_stb_r <= 1'b0;
		end else begin
			rd_stb_r <= rd_stb;
		end
	end

	always_ff @(posedge clk) begin
		addr_r <= addr;
	end

	// second cycle, pick the page
	always_ff @(posedge clk) begin
		if (rst) begin
			data_in <= '0;
		end else if (rd_stb_r) begin
			case (addr_r[LB_AW-1 -: 8])
				PAGE_STATUS: data_in <= status_word;
				PAGE_CTRL: data_in <= mirror_word;
				default: data_in <= UNMAPPED_WORD;
			endcase
		end
	end

	// ------------------------------------------------
	// blocks
	// ------------------------------------------------
	lb_status_bank lb_status_bank_i (
		.clk(clk),
		.rst(rst),
		.rd_stb(rd_stb),
		.addr_lo(addr[3:0]),
		.xdomain_fault(xdomain_fault),
		.tx_mac_done(tx_mac_done),
		.rx_mac_buf_status(rx_mac_buf_status),
		.led_tick(led_tick),
		.led1(led1),
		.led2(led2),
		.status_word(status_word)
	);

	lb_control_regs lb_control_regs_i (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.data_out(data_out),
		.wr_en(wr_en),
		.mirror_we(mirror_we),
		.led_user_mode(led_user_mode),
		.led1_duty(led1_duty),
		.led2_duty(led2_duty),
		.cfg_config(cfg_config),
		.ext_config(ext_config)
	);

	led_pwm led_pwm_i (
		.clk(clk),
		.rst(rst),
		.led1_duty(led1_duty),
		.led2_duty(led2_duty),
		.led1(led1),
		.led2(led2),
		.led_tick(led_tick)
	);

	// same low address bits for write and readback
	lb_mirror_ram lb_mirror_ram_i (
		.clk(clk),
		.we(mirror_we),
		.wr_addr(addr[MIRROR_AW-1:0]),
		.wr_data(data_out),
		.rd_en(rd_stb),
		.rd_addr(addr[MIRROR_AW-1:0]),
		.rd_data(mirror_word)
	);

	// read data holds between reads
	data_in_held: assert property (@(posedge clk) disable iff (rst)
		(!$past(rst) && !$past(rd_stb_r)) |-> $stable(data_in));

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
// ------------------------------------------------
// Testbench clock and reset. 20 ns clock, reset
// held high for the first 8 cycles.
// ------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic rst
);

	localparam int HALF_PERIOD = 10;
	localparam int RESET_CYCLES = 8;

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		// release away from the active edge
		@(negedge clk);
		rst = 1'b0;
	end

	always #(HALF_PERIOD) clk = ~clk;

endmodule

`default_nettype wire

// ==== verification/lb_board_slave_tb.sv ====
// ------------------------------------------------
// Directed testbench for the board local-bus slave.
// Drives bus transfers on the falling edge, checks
// read data, board outputs and PWM behavior.
// ------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module lb_board_slave_tb
	import lb_board_pkg::*;
();

	// pwm and uptime tests dominate, a few thousand cycles
	localparam int TIMEOUT_CYCLES = 40000;
	localparam int UPTIME_TICKS = 4;

	logic clk;
	logic rst;
	logic [LB_AW-1:0] addr;
	logic control_strobe;
	logic control_rd;
	logic [LB_DW-1:0] data_out;
	logic xdomain_fault;
	logic tx_mac_done;
	logic [1:0] rx_mac_buf_status;
	logic [LB_DW-1:0] data_in;
	logic led_user_mode;
	logic led1;
	logic led2;
	logic [3:0] cfg_config;
	logic [3:0] ext_config;

	int seed;
	int error_count;
	int check_count;
	int cycle_count = 0;
	logic [LB_DW-1:0] mirror_exp [32];

	tb_clock_gen clock_gen_i (
		.clk(clk),
		.rst(rst)
	);

	lb_board_slave lb_board_slave_i (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.control_strobe(control_strobe),
		.control_rd(control_rd),
		.data_out(data_out),
		.xdomain_fault(xdomain_fault),
		.tx_mac_done(tx_mac_done),
		.rx_mac_buf_status(rx_mac_buf_status),
		.data_in(data_in),
		.led_user_mode(led_user_mode),
		.led1(led1),
		.led2(led2),
		.cfg_config(cfg_config),
		.ext_config(ext_config)
	);

	// ------------------------------------------------
	// bus helpers
	// ------------------------------------------------
	function automatic logic [LB_AW-1:0] page_addr(input logic [7:0] page,
		input logic [4:0] offset);
		return {page, 11'd0, offset};
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("FAIL %s: expected %h, actual %h at %0t", name, expected, actual, $time);
		end
	endtask

	task automatic drive_bus(input logic strobe, input logic rd,
		input logic [LB_AW-1:0] a, input logic [LB_DW-1:0] d);
		@(negedge clk);
		control_strobe = strobe;
		control_rd = rd;
		addr = a;
		data_out = d;
	endtask

	task automatic bus_write(input logic [LB_AW-1:0] a, input logic [LB_DW-1:0] d);
		drive_bus(1'b1, 1'b0, a, d);
		drive_bus(1'b0, 1'b0, a, d);
	endtask

	// strobe edge, then the page select edge
	task automatic bus_read(input logic [LB_AW-1:0] a, output logic [LB_DW-1:0] d);
		drive_bus(1'b1, 1'b1, a, '0);
		drive_bus(1'b0, 1'b0, a, '0);
		@(negedge clk);
		d = data_in;
	endtask

	// two reads in flight at once
	task automatic read_pair(input logic [LB_AW-1:0] a0, input logic [LB_AW-1:0] a1,
		output logic [LB_DW-1:0] d0, output logic [LB_DW-1:0] d1);
		drive_bus(1'b1, 1'b1, a0, '0);
		drive_bus(1'b1, 1'b1, a1, '0);
		drive_bus(1'b0, 1'b0, a1, '0);
		d0 = data_in;
		@(negedge clk);
		d1 = data_in;
	endtask

	task automatic write_then_read(input logic [LB_AW-1:0] wa, input logic [LB_DW-1:0] wd,
		input logic [LB_AW-1:0] ra, output logic [LB_DW-1:0] d);
		drive_bus(1'b1, 1'b0, wa, wd);
		drive_bus(1'b1, 1'b1, ra, '0);
		drive_bus(1'b0, 1'b0, ra, '0);
		@(negedge clk);
		d = data_in;
	endtask

	// ------------------------------------------------
	// tests
	// ------------------------------------------------
	task automatic test_reset_identity();
		logic [LB_DW-1:0] word;
		check_value("reset led_user_mode", 32'd0, {31'd0, led_user_mode});
		check_value("reset leds", 32'd0, {30'd0, led2, led1});
		check_value("reset config", {24'd0, MISC_CONFIG_DEFAULT},
			{24'd0, ext_config, cfg_config});
		bus_read(page_addr(PAGE_STATUS, 5'd0), word);
		check_value("id word 0", ID_WORD_0, word);
		bus_read(page_addr(PAGE_STATUS, 5'd1), word);
		check_value("id word 1", ID_WORD_1, word);
		bus_read(page_addr(PAGE_STATUS, 5'd2), word);
		check_value("id word 2", ID_WORD_2, word);
		bus_read(page_addr(PAGE_STATUS, 5'd3), word);
		check_value("id word 3", ID_WORD_3, word);
	endtask

	task automatic test_mirror();
		logic [5:0] n;
		logic [LB_DW-1:0] word;
		logic [LB_DW-1:0] rd0;
		logic [LB_DW-1:0] rd1;
		for (n = 6'd0; n < 6'd32; n = n + 6'd1) begin
			word = $random(seed);
			mirror_exp[n[4:0]] = word;
			bus_write(page_addr(PAGE_CTRL, n[4:0]), word);
		end
		for (n = 6'd0; n < 6'd32; n = n + 6'd1) begin
			bus_read(page_addr(PAGE_CTRL, n[4:0]), rd0);
			check_value("mirror read", mirror_exp[n[4:0]], rd0);
		end
		// back to back, walking from both ends
		for (n = 6'd0; n < 6'd32; n = n + 6'd2) begin
			read_pair(page_addr(PAGE_CTRL, n[4:0]), page_addr(PAGE_CTRL, 5'd31 - n[4:0]),
				rd0, rd1);
			check_value("mirror pair first", mirror_exp[n[4:0]], rd0);
			check_value("mirror pair second", mirror_exp[5'd31 - n[4:0]], rd1);
		end
		word = $random(seed);
		mirror_exp[17] = word;
		write_then_read(page_addr(PAGE_CTRL, 5'd17), word, page_addr(PAGE_CTRL, 5'd17), rd0);
		check_value("mirror write then read", word, rd0);
	endtask

	task automatic read_unmapped(input logic [7:0] page, input logic [4:0] offset);
		logic [LB_DW-1:0] word;
		bus_read(page_addr(page, offset), word);
		check_value("unmapped page", UNMAPPED_WORD, word);
	endtask

	task automatic test_unmapped();
		logic [5:0] n;
		logic [7:0] page;
		logic [31:0] r;
		logic [LB_DW-1:0] rd0;
		logic [LB_DW-1:0] rd1;
		read_unmapped(8'h01, 5'd0);
		read_unmapped(8'h04, 5'd3);
		read_unmapped(8'h06, 5'd8);
		read_unmapped(8'hff, 5'd31);
		for (n = 6'd0; n < 6'd4; n = n + 6'd1) begin
			page = PAGE_STATUS;
			while (page == PAGE_STATUS || page == PAGE_CTRL) begin
				r = $random(seed);
				page = r[23:16];
			end
			read_unmapped(page, r[4:0]);
		end
		// unmapped followed directly by a status read at another offset
		read_pair(page_addr(8'h06, 5'd2), page_addr(PAGE_STATUS, 5'd0), rd0, rd1);
		check_value("unmapped pair first", UNMAPPED_WORD, rd0);
		check_value("unmapped pair second", ID_WORD_0, rd1);
	endtask

	task automatic test_faults_and_config();
		logic [31:0] r;
		logic [31:0] k;
		logic [31:0] j;
		logic [7:0] cfg_byte;
		logic [LB_DW-1:0] word;
		r = $random(seed);
		k = 32'd1 + (r % 32'd20);
		for (j = 32'd0; j < k; j = j + 32'd1) begin
			@(negedge clk);
			xdomain_fault = 1'b1;
			@(negedge clk);
			xdomain_fault = 1'b0;
		end
		bus_read(page_addr(PAGE_STATUS, {1'b0, ST_FAULT_CNT}), word);
		check_value("fault count", k, word);

		tx_mac_done = 1'b1;
		rx_mac_buf_status = 2'b10;
		@(negedge clk);
		bus_read(page_addr(PAGE_STATUS, {1'b0, ST_MAC_STAT}), word);
		check_value("mac status", 32'h5, word);

		bus_write(page_addr(PAGE_CTRL, CR_LED_USER), 32'd1);
		check_value("led_user_mode set", 32'd1, {31'd0, led_user_mode});
		bus_write(page_addr(PAGE_CTRL, CR_LED_USER), 32'd0);
		check_value("led_user_mode clear", 32'd0, {31'd0, led_user_mode});
		r = $random(seed);
		cfg_byte = r[7:0];
		bus_write(page_addr(PAGE_CTRL, CR_MISC_CONFIG), {24'd0, cfg_byte});
		check_value("cfg_config", {28'd0, cfg_byte[3:0]}, {28'd0, cfg_config});
		check_value("ext_config", {28'd0, cfg_byte[7:4]}, {28'd0, ext_config});
	endtask

	task automatic test_pwm();
		logic [31:0] r;
		logic [7:0] duty;
		logic [10:0] c;
		logic [31:0] high1;
		logic [31:0] high2;
		r = $random(seed);
		duty = 8'd1 + (r[7:0] % 8'd255);
		bus_write(page_addr(PAGE_CTRL, CR_LED1_DUTY), {24'd0, duty});
		bus_write(page_addr(PAGE_CTRL, CR_LED2_DUTY), 32'd0);
		// one full period plus the LED register
		repeat ((1 << LED_CW) + 6) @(negedge clk);
		high1 = 32'd0;
		high2 = 32'd0;
		for (c = 11'd0; c < 11'd1024; c = c + 11'd1) begin
			@(negedge clk);
			if (led1) begin
				high1 = high1 + 32'd1;
			end
			if (led2) begin
				high2 = high2 + 32'd1;
			end
		end
		check_value("led1 high cycles", 32'd4 * {24'd0, duty}, high1);
		check_value("led2 dark at zero duty", 32'd0, high2);
	endtask

	task automatic test_uptime();
		logic [LB_DW-1:0] up0;
		logic [LB_DW-1:0] up1;
		bus_read(page_addr(PAGE_STATUS, {1'b0, ST_UPTIME}), up0);
		// next strobe exactly UPTIME_TICKS periods after the first
		repeat ((UPTIME_TICKS << LED_CW) - 3) @(negedge clk);
		bus_read(page_addr(PAGE_STATUS, {1'b0, ST_UPTIME}), up1);
		check_value("uptime step", UPTIME_TICKS, up1 - up0);
	endtask

	// ------------------------------------------------
	// run control
	// ------------------------------------------------
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	initial begin
		seed = 42996;
		error_count = 0;
		check_count = 0;
		addr = '0;
		control_strobe = 1'b0;
		control_rd = 1'b0;
		data_out = '0;
		xdomain_fault = 1'b0;
		tx_mac_done = 1'b0;
		rx_mac_buf_status = 2'b00;

		@(negedge rst);
		test_reset_identity();
		test_mirror();
		test_unmapped();
		test_faults_and_config();
		test_pwm();
		test_uptime();

		$display("%0d errors in %0d checks", error_count, check_count);
		if (error_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== lb_board_slave.f ====
hw/lb_board_pkg.sv
hw/lb_status_bank.sv
hw/lb_control_regs.sv
hw/led_pwm.sv
hw/lb_mirror_ram.sv
hw/lb_board_slave.sv
verification/tb_clock_gen.sv
verification/lb_board_slave_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the board slave testbench with Verilator and run it.
# Exit status is non-zero unless the log holds the pass line.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module lb_board_slave_tb \
	-f lb_board_slave.f \
	--Mdir obj_dir \
	-o lb_board_slave_sim

./obj_dir/lb_board_slave_sim | tee sim.log

if grep -q "^ALL CHECKS PASSED$" sim.log; then
	echo "simulation result: pass"
else
	echo "simulation result: fail, see sim.log"
	exit 1
fi
